// ==== include/ac97_config.svh ====
//----------------------------------------
// integer constants of the ac97 block
// fifo depth must be a power of two, tick counts fit 12 bits
//----------------------------------------
`ifndef AC97_CONFIG_SVH
`define AC97_CONFIG_SVH

//----------------------------------------
// sample fifos
//----------------------------------------
`define AC97_FIFO_DEPTH      16    // stereo words per direction

//----------------------------------------
// 48 kHz divider on the 125 MHz clock
//----------------------------------------
`define AC97_TICK_SHORT      2604  // cycles per short run
`define AC97_TICK_RUNS       5     // short runs before one long run

//----------------------------------------
// interrupt levels, see irq_level_e
//----------------------------------------
`define AC97_PLAY_IRQ_LEVEL  2     // half empty
`define AC97_REC_IRQ_LEVEL   3     // half full

`endif

// ==== hw/ac97_pkg.sv ====
//----------------------------------------
// types shared by the ac97 controller RTL
// bus offsets use the low 20 address bits only
//----------------------------------------
package ac97_pkg;

  // byte offsets on the system bus
  typedef enum logic [19:0] {
    FIFO_PLAY        = 20'h00000, // wo, left then right half
    FIFO_REC         = 20'h00004, // ro, left then right half
    STATUS           = 20'h00008, // ro
    FIFO_RESET       = 20'h0000C, // wo, bit0 play bit1 rec
    CODEC_ADDR       = 20'h00010, // wo, bit7 read, bits 6..1 word
    CODEC_DATA_READ  = 20'h00014, // ro
    CODEC_DATA_WRITE = 20'h00018  // wo
  } ac97_reg_e;

  typedef enum logic [2:0] {
    NONE       = 3'd0, // never fires
    EMPTY      = 3'd1, // count is 0
    HALF_EMPTY = 3'd2, // count below half
    HALF_FULL  = 3'd3, // count at half or more
    FULL       = 3'd4  // count at depth
  } irq_level_e;

  typedef struct packed {
    logic [15:0] right; // high half
    logic [15:0] left;  // low half
  } stereo_sample_t;

  typedef struct packed {
    logic empty;
    logic half_empty;
    logic half_full;
    logic full;
  } fifo_flags_t;

  typedef struct packed {
    logic rec_overrun;    // bit 7, sticky
    logic play_underrun;  // sticky
    logic codec_ready;
    logic access_done;
    logic rec_empty;
    logic rec_full;
    logic play_half_full;
    logic play_full;      // bit 0
  } ac97_status_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  sel;
    logic        wen;   // one cycle per request
    logic        ren;
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata; // valid with ack
    logic        ack;
  } sys_rsp_t;

  typedef struct packed {
    logic [5:0]  addr;   // codec word address
    logic [15:0] wdata;
    logic        store;  // one cycle pulse
    logic        recall; // one cycle pulse
  } codec_cmd_t;

endpackage

// ==== hw/ac97_rate_gen.sv ====
`timescale 1ns/1ps
//----------------------------------------
// 48 kHz sample tick from 125 MHz, one cycle wide
// five short runs then one long run, 48 kHz on average
//----------------------------------------
`include "ac97_config.svh"

module ac97_rate_gen (
  input  logic clk_adc_125mhz, // adc clock
  input  logic adc_rstn_i,     // sync reset, active low
  output logic tick_o          // sample tick
);

  localparam logic [11:0] SHORT_LAST = 12'(`AC97_TICK_SHORT - 1);
  localparam logic [11:0] LONG_LAST  = 12'(`AC97_TICK_SHORT);
  localparam logic [2:0]  RUNS       = 3'(`AC97_TICK_RUNS);

  logic [11:0] cnt_q; // cycles in this run
  logic [2:0]  run_q; // short runs done
  logic        wrap;

  assign wrap = (cnt_q == ((run_q == RUNS) ? LONG_LAST : SHORT_LAST)); // end of run

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      cnt_q  <= '0;
      run_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      tick_o <= wrap;                 // registered pulse
      if (wrap) begin
        cnt_q <= '0;
        run_q <= (run_q == RUNS) ? 3'd0 : run_q + 3'd1; // long run restarts the set
      end else begin
        cnt_q <= cnt_q + 12'd1;
      end
    end
  end

  // tick is never two cycles wide
  a_tick_single : assert property (
    @(posedge clk_adc_125mhz) disable iff (!adc_rstn_i) tick_o |=> !tick_o
  );

endmodule

// ==== hw/ac97_sample_fifo.sv ====
`timescale 1ns/1ps
//----------------------------------------
// stereo sample fifo with a fall-through head
// push while full is dropped, pop while empty does nothing
//----------------------------------------
`include "ac97_config.svh"

module ac97_sample_fifo import ac97_pkg::*; (
  input  logic           clk_adc_125mhz, // adc clock
  input  logic           adc_rstn_i,     // sync reset, active low
  input  logic           clear_i,        // fifo reset pulse
  input  logic           push_i,
  input  stereo_sample_t push_data_i,
  input  logic           pop_i,
  output stereo_sample_t head_o,         // oldest word, or last popped when empty
  output fifo_flags_t    flags_o
);

  localparam int DEPTH = `AC97_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam logic [AW:0] CNT_HALF = (AW + 1)'(DEPTH / 2);
  localparam logic [AW:0] CNT_FULL = (AW + 1)'(DEPTH);

  stereo_sample_t mem [DEPTH];
  stereo_sample_t hold_q;   // last popped word
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [AW:0]    count_q;  // 0 .. DEPTH
  logic           do_push;
  logic           do_pop;

  assign do_push = push_i && !flags_o.full;
  assign do_pop  = pop_i && !flags_o.empty;
  assign head_o  = flags_o.empty ? hold_q : mem[rd_ptr_q]; // head stays on empty pop

  always_comb begin
    flags_o.empty      = (count_q == '0);
    flags_o.half_empty = (count_q < CNT_HALF);
    flags_o.half_full  = (count_q >= CNT_HALF);
    flags_o.full       = (count_q == CNT_FULL);
  end

  // sample storage
  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
    if (do_pop) begin
      hold_q <= mem[rd_ptr_q];
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;     // both or neither
      endcase
    end
  end

  a_count_bound : assert property (
    @(posedge clk_adc_125mhz) disable iff (!adc_rstn_i) count_q <= CNT_FULL
  );

endmodule

// ==== hw/ac97_fifo_irq.sv ====
`timescale 1ns/1ps
//----------------------------------------
// level interrupt, set when the fifo enters LEVEL
// cleared on empty (on not empty for EMPTY) and on fifo reset
//----------------------------------------
module ac97_fifo_irq import ac97_pkg::*; #(
  parameter irq_level_e LEVEL = HALF_EMPTY
) (
  input  logic        clk_adc_125mhz, // adc clock
  input  logic        adc_rstn_i,     // sync reset, active low
  input  logic        clear_i,        // fifo reset pulse
  input  fifo_flags_t flags_i,
  output logic        irq_o
);

  fifo_flags_t prev_q;   // flags one cycle back
  logic        cur_sel;
  logic        prev_sel;
  logic        drop;

  function automatic logic pick(input fifo_flags_t f);
    case (LEVEL)
      EMPTY:      return f.empty;
      HALF_EMPTY: return f.half_empty;
      HALF_FULL:  return f.half_full;
      FULL:       return f.full;
      default:    return 1'b0;  // NONE
    endcase
  endfunction

  assign cur_sel  = pick(flags_i);
  assign prev_sel = pick(prev_q);
  assign drop     = (LEVEL == EMPTY) ? !flags_i.empty : flags_i.empty; // level left

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      prev_q <= '0;
      irq_o  <= 1'b0;
    end else begin
      prev_q <= flags_i;
      if (clear_i || LEVEL == NONE || drop) begin
        irq_o <= 1'b0;
      end else if (cur_sel && !prev_sel) begin
        irq_o <= 1'b1;                         // rising edge of the level
      end
    end
  end

endmodule

// ==== hw/ac97_codec_regs.sv ====
`timescale 1ns/1ps
//----------------------------------------
// codec register shadow, 64 words of 16 bits
// done two cycles after a store, four after a recall
//----------------------------------------
module ac97_codec_regs import ac97_pkg::*; (
  input  logic        clk_adc_125mhz, // adc clock
  input  logic        adc_rstn_i,     // sync reset, active low
  input  codec_cmd_t  cmd_i,          // addr and data held between pulses
  output logic [15:0] read_data_o,
  output logic        access_done_o,
  output logic        play_down_o,    // play path powered down
  output logic        rec_down_o      // record path powered down
);

  localparam logic [5:0] PWRDN_WORD = 6'h13; // codec byte address 0x26

  logic [15:0] shadow [64];
  logic [1:0]  recall_d;  // recall delay line
  logic        finish_q;  // access completes next cycle
  logic        done_q;
  logic        is_pwrdn;

  assign is_pwrdn      = (cmd_i.addr == PWRDN_WORD);
  assign access_done_o = done_q && !(cmd_i.store || cmd_i.recall); // low from the ack on

  //----------------------------------------
  // shadow memory and readback
  //----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (cmd_i.store) begin
      shadow[cmd_i.addr] <= cmd_i.wdata;
    end
    if (recall_d[1]) begin
      read_data_o <= shadow[cmd_i.addr] | (is_pwrdn ? 16'h000F : 16'h0000); // ready bits
    end
  end

  //----------------------------------------
  // sequencing and power-down decode
  //----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      recall_d    <= '0;
      finish_q    <= 1'b0;
      done_q      <= 1'b0;
      play_down_o <= 1'b0;
      rec_down_o  <= 1'b0;
    end else begin
      recall_d <= {recall_d[0], cmd_i.recall};
      finish_q <= cmd_i.store || recall_d[1];
      if (cmd_i.store || cmd_i.recall) begin
        done_q <= 1'b0;                  // new access started
      end else if (finish_q) begin
        done_q <= 1'b1;
      end
      if (cmd_i.store && is_pwrdn) begin
        play_down_o <= cmd_i.wdata[13] || cmd_i.wdata[12] || cmd_i.wdata[9]; // pr1 pr4 pr5
        rec_down_o  <= cmd_i.wdata[13] || cmd_i.wdata[12] || cmd_i.wdata[8]; // pr0 pr4 pr5
      end
    end
  end

endmodule

// ==== hw/ac97_bus_regs.sv ====
`timescale 1ns/1ps
//----------------------------------------
// system bus slave, each request acked the next cycle
// no stall path, a push to a full play fifo is lost
//----------------------------------------
module ac97_bus_regs import ac97_pkg::*; (
  input  logic           clk_adc_125mhz,  // adc clock
  input  logic           adc_rstn_i,      // sync reset, active low
  input  sys_req_t       req_i,
  output sys_rsp_t       rsp_o,
  input  fifo_flags_t    play_flags_i,
  input  fifo_flags_t    rec_flags_i,
  input  logic           play_underrun_i, // sticky
  input  logic           rec_overrun_i,   // sticky
  input  stereo_sample_t rec_head_i,
  input  logic [15:0]    codec_data_i,
  input  logic           access_done_i,
  output codec_cmd_t     codec_cmd_o,
  output logic           play_push_o,     // one cycle after the right half
  output stereo_sample_t play_sample_o,
  output logic           rec_pop_o,       // with the right half read
  output logic           play_clear_o,
  output logic           rec_clear_o
);

  ac97_reg_e    offset;
  ac97_status_t status;
  logic [31:0]  rdata;
  logic [31:0]  rdata_q;
  logic         ack_q;
  logic         play_half_q; // left held, right next
  logic         rec_half_q;  // left read, right next
  logic [15:0]  left_q;
  logic [15:0]  right_q;

  assign offset        = ac97_reg_e'(req_i.addr[19:0]);
  assign rsp_o         = '{rdata: rdata_q, ack: ack_q};
  assign play_sample_o = '{right: right_q, left: left_q};
  assign rec_pop_o     = req_i.ren && (offset == FIFO_REC) && rec_half_q;

  always_comb begin
    status.rec_overrun    = rec_overrun_i;
    status.play_underrun  = play_underrun_i;
    status.codec_ready    = 1'b1;          // no post-reset delay
    status.access_done    = access_done_i;
    status.rec_empty      = rec_flags_i.empty;
    status.rec_full       = rec_flags_i.full;
    status.play_half_full = play_flags_i.half_full;
    status.play_full      = play_flags_i.full;
  end

  always_comb begin
    case (offset)
      FIFO_REC:        rdata = {16'h0, rec_half_q ? rec_head_i.right : rec_head_i.left};
      STATUS:          rdata = {24'h0, status};
      CODEC_DATA_READ: rdata = {16'h0, codec_data_i};
      default:         rdata = 32'h0;  // write only or unknown
    endcase
  end

  // read data and play halves
  always_ff @(posedge clk_adc_125mhz) begin
    if (req_i.ren) begin
      rdata_q <= rdata;
    end
    if (req_i.wen && offset == FIFO_PLAY) begin
      if (play_half_q) begin
        right_q <= req_i.wdata[15:0];
      end else begin
        left_q <= req_i.wdata[15:0];
      end
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ack_q        <= 1'b0;
      play_half_q  <= 1'b0;
      rec_half_q   <= 1'b0;
      play_push_o  <= 1'b0;
      play_clear_o <= 1'b0;
      rec_clear_o  <= 1'b0;
      codec_cmd_o  <= '0;
    end else begin
      ack_q              <= req_i.wen || req_i.ren; // one ack per request
      play_push_o        <= 1'b0;                   // pulses default low
      play_clear_o       <= 1'b0;
      rec_clear_o        <= 1'b0;
      codec_cmd_o.store  <= 1'b0;
      codec_cmd_o.recall <= 1'b0;
      if (req_i.ren && offset == FIFO_REC) begin
        rec_half_q <= !rec_half_q;
      end
      if (req_i.wen) begin
        case (offset)
          FIFO_PLAY: begin
            play_half_q <= !play_half_q;
            play_push_o <= play_half_q;   // pair complete
          end
          FIFO_RESET: begin
            if (req_i.wdata[0]) begin
              play_half_q  <= 1'b0;
              play_clear_o <= 1'b1;
            end
            if (req_i.wdata[1]) begin
              rec_half_q  <= 1'b0;
              rec_clear_o <= 1'b1;
            end
          end
          CODEC_ADDR: begin
            codec_cmd_o.addr   <= req_i.wdata[6:1];
            codec_cmd_o.recall <= req_i.wdata[7];
            codec_cmd_o.store  <= !req_i.wdata[7];
          end
          CODEC_DATA_WRITE: codec_cmd_o.wdata <= req_i.wdata[15:0];
          default: ;                       // read only offsets ignored
        endcase
      end
    end
  end

endmodule

// ==== hw/ac97_ctrl_top.sv ====
`timescale 1ns/1ps
//----------------------------------------
// ac97 controller emulation on the adc clock
// line ports carry left in the low half, right in the high half
//----------------------------------------
`include "ac97_config.svh"

module ac97_ctrl_top import ac97_pkg::*; (
  input  logic           clk_adc_125mhz, // adc clock
  input  logic           adc_rstn_i,     // sync reset, active low
  input  sys_req_t       sys_req_i,
  output sys_rsp_t       sys_rsp_o,
  input  stereo_sample_t line_in_i,
  output stereo_sample_t line_out_o,     // play fifo head
  output logic           tick_48k_o,
  output logic           irq_play_o,
  output logic           irq_rec_o
);

  logic           tick;
  logic           play_down;
  logic           rec_down;
  logic           play_push;
  logic           rec_pop;
  logic           play_clear;
  logic           rec_clear;
  logic           play_underrun_q;
  logic           rec_overrun_q;
  logic           access_done;
  logic [15:0]    codec_data;
  stereo_sample_t play_sample;
  stereo_sample_t rec_head;
  fifo_flags_t    play_flags;
  fifo_flags_t    rec_flags;
  codec_cmd_t     codec_cmd;

  assign tick_48k_o = tick;

  ac97_rate_gen u_rate (.clk_adc_125mhz, .adc_rstn_i, .tick_o(tick));

  ac97_sample_fifo u_play_fifo (
    .clk_adc_125mhz, .adc_rstn_i, .clear_i(play_clear),
    .push_i(play_push), .push_data_i(play_sample),
    .pop_i(tick && !play_down),               // drained by the tick
    .head_o(line_out_o), .flags_o(play_flags)
  );

  ac97_sample_fifo u_rec_fifo (
    .clk_adc_125mhz, .adc_rstn_i, .clear_i(rec_clear),
    .push_i(tick && !rec_down), .push_data_i(line_in_i), // filled by the tick
    .pop_i(rec_pop), .head_o(rec_head), .flags_o(rec_flags)
  );

  ac97_fifo_irq #(.LEVEL(irq_level_e'(`AC97_PLAY_IRQ_LEVEL))) u_play_irq (
    .clk_adc_125mhz, .adc_rstn_i, .clear_i(play_clear), .flags_i(play_flags), .irq_o(irq_play_o)
  );

  ac97_fifo_irq #(.LEVEL(irq_level_e'(`AC97_REC_IRQ_LEVEL))) u_rec_irq (
    .clk_adc_125mhz, .adc_rstn_i, .clear_i(rec_clear), .flags_i(rec_flags), .irq_o(irq_rec_o)
  );

  ac97_codec_regs u_codec (
    .clk_adc_125mhz, .adc_rstn_i, .cmd_i(codec_cmd), .read_data_o(codec_data),
    .access_done_o(access_done), .play_down_o(play_down), .rec_down_o(rec_down)
  );

  ac97_bus_regs u_bus (
    .clk_adc_125mhz, .adc_rstn_i, .req_i(sys_req_i), .rsp_o(sys_rsp_o),
    .play_flags_i(play_flags), .rec_flags_i(rec_flags),
    .play_underrun_i(play_underrun_q), .rec_overrun_i(rec_overrun_q),
    .rec_head_i(rec_head), .codec_data_i(codec_data), .access_done_i(access_done),
    .codec_cmd_o(codec_cmd), .play_push_o(play_push), .play_sample_o(play_sample),
    .rec_pop_o(rec_pop), .play_clear_o(play_clear), .rec_clear_o(rec_clear)
  );

  //----------------------------------------
  // sticky error flags
  //----------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || play_clear) begin
      play_underrun_q <= 1'b0;
    end else if (tick && play_flags.empty) begin
      play_underrun_q <= 1'b1;              // nothing to play
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || rec_clear) begin
      rec_overrun_q <= 1'b0;
    end else if (tick && rec_flags.full) begin
      rec_overrun_q <= 1'b1;                // sample dropped
    end
  end

endmodule

// ==== tb/ac97_ctrl_tb.sv ====
`timescale 1ns/1ps
//----------------------------------------
// case file testbench, run from the project root
// record model assumes no fifo read while the record fifo is full
//----------------------------------------
`include "ac97_config.svh"

module ac97_ctrl_tb import ac97_pkg::*; ();

  localparam int MAX_CASES  = 128;
  localparam int DEPTH      = `AC97_FIFO_DEPTH;
  localparam int TICK_SHORT = `AC97_TICK_SHORT;
  localparam int TICK_RUNS  = `AC97_TICK_RUNS;

  typedef enum logic [3:0] {
    OP_END      = 4'd0,
    OP_WRITE    = 4'd1,
    OP_READ     = 4'd2, // data column is the compare mask
    OP_WAIT     = 4'd3, // data column is the tick count
    OP_IRQ      = 4'd4, // addr 0 play, 1 rec
    OP_LINE_OUT = 4'd5,
    OP_REC      = 4'd6, // pairs read back against recorded line_in
    OP_POLL     = 4'd7, // status poll, data is the mask
    OP_PLAY     = 4'd8  // addr is the pair pattern, data the count
  } case_op_e;

  logic           clk_adc_125mhz;
  logic           adc_rstn;
  sys_req_t       sys_req;
  sys_rsp_t       sys_rsp;
  stereo_sample_t line_in;
  stereo_sample_t line_out;
  logic           tick_48k;
  logic           irq_play;
  logic           irq_rec;

  logic [31:0]    cases_mem [4*MAX_CASES];
  stereo_sample_t rec_q [$];    // line_in values the record fifo should hold
  stereo_sample_t pending;      // sample taken on the coming tick edge
  logic           pending_vld;
  logic           rec_on;       // record path powered up
  logic [15:0]    codec_wdata;  // last CODEC_DATA_WRITE value
  logic [15:0]    in_cnt;
  int             tick_gap;     // cycles since the last tick
  int             tick_idx;     // ticks seen so far
  int             mismatches;
  int             failures;
  int             checks;
  int             num_cases;
  int             max_wait;
  longint         watchdog_ns;

  ac97_ctrl_top ac97_ctrl_top_inst (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn),
    .sys_req_i      (sys_req),
    .sys_rsp_o      (sys_rsp),
    .line_in_i      (line_in),
    .line_out_o     (line_out),
    .tick_48k_o     (tick_48k),
    .irq_play_o     (irq_play),
    .irq_rec_o      (irq_rec)
  );

  initial begin
    clk_adc_125mhz = 1'b0;
    forever #4 clk_adc_125mhz = ~clk_adc_125mhz; // 125 MHz
  end

  function automatic stereo_sample_t line_sample(input logic [15:0] n);
    return '{right: n ^ 16'hC000, left: n}; // halves differ
  endfunction

  // ticks numbered from one after reset, every sixth ends a long run
  function automatic int tick_interval(input int num);
    return (num % (TICK_RUNS + 1) == 0) ? TICK_SHORT + 1 : TICK_SHORT;
  endfunction

  //----------------------------------------
  // line input source and record model
  //----------------------------------------
  always begin
    @(posedge clk_adc_125mhz);
    #1;
    if (pending_vld) begin
      if (rec_on && rec_q.size() < DEPTH) begin
        rec_q.push_back(pending);        // full fifo drops it
      end
      pending_vld = 1'b0;
      in_cnt      = in_cnt + 16'd1;
      line_in     = line_sample(in_cnt);  // step after the tick
    end
    if (tick_48k && adc_rstn) begin
      pending     = line_in;             // pushed on the next edge
      pending_vld = 1'b1;
    end
  end

  //----------------------------------------
  // tick spacing
  //----------------------------------------
  always begin
    @(posedge clk_adc_125mhz);
    #1;
    if (adc_rstn) begin
      tick_gap++;
      if (tick_48k) begin
        if (tick_idx > 0) begin
          compare_value("tick_48k_o interval", tick_gap, tick_interval(tick_idx + 1));
        end
        tick_gap = 0;
        tick_idx++;
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("ERROR %s at %0t", what, $time);
  endtask

  // one request, starts and ends 1 ns after a rising edge
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    if (sys_rsp.ack) begin
      report_failure("ack seen before the request was driven");
    end
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.sel   = 4'hF;
    sys_req.wen   = wr;
    sys_req.ren   = !wr;
    @(posedge clk_adc_125mhz);
    #1;
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    if (!sys_rsp.ack) begin
      report_failure("no ack on the cycle after the request");
    end
    rdata = sys_rsp.rdata;
    @(posedge clk_adc_125mhz);
    #1;
    if (sys_rsp.ack) begin
      report_failure("ack lasted more than one cycle");
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
    if (addr == 32'h18) begin
      codec_wdata = data[15:0];
    end
    if (addr == 32'h10 && !data[7] && data[6:1] == 6'h13) begin
      rec_on = !(codec_wdata[8] || codec_wdata[12] || codec_wdata[13]); // pr0 pr4 pr5
    end
    if (addr == 32'h0C && data[1]) begin
      rec_q.delete();                   // record fifo reset
    end
  endtask

  task automatic poll_status(input logic [31:0] mask, input logic [31:0] exp);
    logic [31:0] rd;
    int          tries;
    rd = ~exp;
    for (tries = 0; tries < 16; tries++) begin
      bus_access(1'b0, 32'h08, 32'h0, rd);
      if ((rd & mask) == exp) break;
    end
    if ((rd & mask) != exp) begin
      report_failure("status polling never reached the expected bits");
    end
  endtask

  // pair i is base plus i in each half
  task automatic push_pairs(input logic [31:0] base, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      write_reg(32'h00, {16'h0, base[15:0] + 16'(i)});   // left first
      write_reg(32'h00, {16'h0, base[31:16] + 16'(i)});
    end
  endtask

  // returns two edges after the last tick, pop and irq settled
  task automatic wait_ticks(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      do begin
        @(posedge clk_adc_125mhz);
        #1;
      end while (!tick_48k);
    end
    repeat (2) begin
      @(posedge clk_adc_125mhz);
      #1;
    end
  endtask

  task automatic verify_rec_pairs(input int n);
    stereo_sample_t exp;
    logic [31:0]    rd;
    int             k;
    for (k = 0; k < n; k++) begin
      if (rec_q.size() == 0) begin
        report_failure("record model holds no sample to compare");
        return;
      end
      exp = rec_q.pop_front();
      bus_access(1'b0, 32'h04, 32'h0, rd);
      compare_value("FIFO_REC left", rd, {16'h0, exp.left});
      bus_access(1'b0, 32'h04, 32'h0, rd);
      compare_value("FIFO_REC right", rd, {16'h0, exp.right});
    end
  endtask

  //----------------------------------------
  // watchdog, cases x longest wait x long run
  //----------------------------------------
  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("watchdog expired, the case list did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    logic [31:0] rd;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    case_op_e    op;
    int          i;
    sys_req     = '0;
    adc_rstn    = 1'b0;
    in_cnt      = 16'd0;
    line_in     = line_sample(16'd0);
    pending     = '0;
    pending_vld = 1'b0;
    rec_on      = 1'b1;
    codec_wdata = 16'h0;
    tick_gap    = 0;
    tick_idx    = 0;
    mismatches  = 0;
    failures    = 0;
    checks      = 0;
    max_wait    = 1;
    watchdog_ns = 0;
    for (i = 0; i < 4*MAX_CASES; i++) begin
      cases_mem[i] = '0;
    end
    $readmemh("tb/ac97_cases.mem", cases_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && cases_mem[4*num_cases][3:0] != 4'd0) begin
      if (cases_mem[4*num_cases][3:0] == OP_WAIT && cases_mem[4*num_cases+2] > max_wait) begin
        max_wait = cases_mem[4*num_cases+2];
      end
      num_cases++;
    end
    if (num_cases == 0) begin
      report_failure("case file is empty or missing");
    end
    watchdog_ns = longint'(num_cases + 1) * longint'(max_wait) * 2605 * 8;
    repeat (8) @(posedge clk_adc_125mhz);        // reset for 8 cycles
    #1;
    adc_rstn = 1'b1;
    for (i = 0; i < num_cases; i++) begin
      op   = case_op_e'(cases_mem[4*i][3:0]);
      addr = cases_mem[4*i+1];
      data = cases_mem[4*i+2];
      expv = cases_mem[4*i+3];
      case (op)
        OP_WRITE: write_reg(addr, data);
        OP_READ: begin
          bus_access(1'b0, addr, 32'h0, rd);
          compare_value($sformatf("rdata at 0x%0h", addr), rd & data, expv);
        end
        OP_WAIT:     wait_ticks(data);
        OP_IRQ: begin
          if (addr == 32'h0) begin
            compare_value("irq_play_o", {31'h0, irq_play}, expv);
          end else begin
            compare_value("irq_rec_o", {31'h0, irq_rec}, expv);
          end
        end
        OP_LINE_OUT: compare_value("line_out_o", line_out, expv);
        OP_REC:      verify_rec_pairs(data);
        OP_POLL:     poll_status(data, expv);
        OP_PLAY:     push_pairs(addr, data);
        default:     report_failure($sformatf("unknown opcode in case %0d", i));
      endcase
    end
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/ac97_cases.mem ====
// columns: opcode address data expected, all hex
// 1 write, 2 read (data masks), 3 wait ticks, 4 irq (addr 0 play 1 rec), 5 line_out
// 6 record pairs, 7 poll status (data masks), 8 play pairs, 0 end
// bus decode and status after reset
2 1c ffffffff 0
2 0 ffffffff 0
1 8 ff 0
2 8 ff 28
// codec word 5 write and readback
1 18 1234 0
1 10 a 0
2 8 10 0
7 8 10 10
1 10 8a 0
7 8 10 10
2 14 ffffffff 1234
// record power down at 0x26
1 18 100 0
1 10 26 0
2 8 10 0
7 8 10 10
1 10 a6 0
7 8 10 10
2 14 ffffffff 10f
3 0 2 0
2 8 48 48
// playback pairing and underrun
1 c 1 0
2 8 40 0
8 22001100 8 0
2 8 3 2
4 0 0 0
5 0 0 22001100
3 0 1 0
5 0 0 22011101
4 0 0 1
3 0 1 0
5 0 0 22021102
3 0 6 0
5 0 0 22071107
4 0 0 0
2 8 40 0
3 0 1 0
2 8 40 40
5 0 0 22071107
1 c 1 0
2 8 40 0
// play interrupt cleared by reset
8 33003300 8 0
3 0 1 0
4 0 0 1
1 c 1 0
4 0 0 0
2 8 3 0
// record power up and order
1 18 0 0
1 10 26 0
7 8 10 10
1 c 2 0
3 0 4 0
2 8 c 0
6 0 4 0
2 8 8 8
4 1 0 0
// record interrupt and overrun
3 0 7 0
4 1 0 0
3 0 1 0
4 1 0 1
3 0 9 0
2 8 84 84
4 1 0 1
1 c 2 0
2 8 8c 8
4 1 0 0
3 0 3 0
6 0 3 0
0 0 0 0

// ==== project.f ====
+incdir+include
hw/ac97_pkg.sv
hw/ac97_rate_gen.sv
hw/ac97_sample_fifo.sv
hw/ac97_fifo_irq.sv
hw/ac97_codec_regs.sv
hw/ac97_bus_regs.sv
hw/ac97_ctrl_top.sv
tb/ac97_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the ac97 controller testbench

SRCS := $(shell grep -v '^+' project.f) include/ac97_config.svh

.PHONY: all run clean

all: obj_dir/Vac97_ctrl_tb

obj_dir/Vac97_ctrl_tb: $(SRCS) project.f
	verilator --binary --timing --assert -f project.f --top-module ac97_ctrl_tb -o Vac97_ctrl_tb

# the log decides pass or fail
run: obj_dir/Vac97_ctrl_tb
	./obj_dir/Vac97_ctrl_tb | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
